// ==== design/dbus_decode.sv ====
//////////////////////////////
// Data bus address decode with fault check and target enables
// Purely combinational, sits in front of lanes and targets
//////////////////////////////
`timescale 1ns/1ps

`include "dbus_params.svh"

module dbus_decode import rv32_pkg::*, dbus_pkg::*; (
    input  logic                     rd_en_i,
    input  logic                     wr_en_i,
    input  word_t                    addr_i,
    input  lsu_size_t                size_i,
    input  logic                     axi_busy_i,

    output region_t                  region_o,
    output logic                     fault_o,
    output logic                     accept_o,
    output logic                     wait_o,

    output logic                     rom_rd_en_o,
    output logic                     ram_rd_en_o,
    output logic                     ram_wr_en_o,
    output logic                     mtime_rd_en_o,
    output logic                     mtime_wr_en_o,
    output logic                     axi_rd_en_o,
    output logic                     axi_wr_en_o,
    output logic [`DBUS_ROM_AW-1:0]   rom_addr_o,
    output logic [`DBUS_RAM_AW-1:0]   ram_addr_o,
    output logic [`DBUS_MTIME_AW-1:0] mtime_addr_o,
    output logic [`DBUS_AXI_AW-1:0]   axi_addr_o
);

    // Lowest address bit that selects a region
    localparam int ROM_LSB   = `DBUS_ROM_AW + 2;
    localparam int RAM_LSB   = `DBUS_RAM_AW + 2;
    localparam int MTIME_LSB = `DBUS_MTIME_AW + 2;
    localparam int AXI_LSB   = `DBUS_AXI_AW;

    localparam word_t ROM_BASE   = `DBUS_ROM_BASE;
    localparam word_t RAM_BASE   = `DBUS_RAM_BASE;
    localparam word_t MTIME_BASE = `DBUS_MTIME_BASE;
    localparam word_t AXI_BASE   = `DBUS_AXI_BASE;

    logic req;          // Any access present
    logic misaligned;
    logic go;           // Legal request toward a target
    logic is_axi;

    //////////////////////////////
    // Region match
    //////////////////////////////
    always_comb begin
        if (addr_i[XLEN-1:ROM_LSB] == ROM_BASE[XLEN-1:ROM_LSB]) begin
            region_o = REGION_ROM;
        end else if (addr_i[XLEN-1:RAM_LSB] == RAM_BASE[XLEN-1:RAM_LSB]) begin
            region_o = REGION_RAM;
        end else if (addr_i[XLEN-1:MTIME_LSB] == MTIME_BASE[XLEN-1:MTIME_LSB]) begin
            region_o = REGION_MTIME;
        end else if (addr_i[XLEN-1:AXI_LSB] == AXI_BASE[XLEN-1:AXI_LSB]) begin
            region_o = REGION_AXI;
        end else begin
            region_o = REGION_NONE;
        end
    end

    // Offset versus size
    always_comb begin
        case (size_i)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = addr_i[0];
            SIZE_WORD: misaligned = |addr_i[1:0];
            default:   misaligned = 1'b1;       // Unused size code
        endcase
    end

    //////////////////////////////
    // Fault, wait and accept
    //////////////////////////////
    assign req    = rd_en_i | wr_en_i;
    assign is_axi = (region_o == REGION_AXI);

    assign fault_o = req & (misaligned
                         | (region_o == REGION_NONE)
                         | ((region_o == REGION_ROM) & wr_en_i));   // ROM is read only

    assign go       = req & ~fault_o;
    assign wait_o   = go & is_axi & axi_busy_i;     // Hold request while external busy
    assign accept_o = req & ~wait_o;                // Faults accepted at once

    // Per target enables, exactly one when legal
    assign rom_rd_en_o   = go & rd_en_i & (region_o == REGION_ROM);
    assign ram_rd_en_o   = go & rd_en_i & (region_o == REGION_RAM);
    assign ram_wr_en_o   = go & wr_en_i & (region_o == REGION_RAM);
    assign mtime_rd_en_o = go & rd_en_i & (region_o == REGION_MTIME);
    assign mtime_wr_en_o = go & wr_en_i & (region_o == REGION_MTIME);
    assign axi_rd_en_o   = go & rd_en_i & is_axi & ~axi_busy_i;
    assign axi_wr_en_o   = go & wr_en_i & is_axi & ~axi_busy_i;

    // Word addresses for local targets, byte address for AXI
    assign rom_addr_o   = addr_i[ROM_LSB-1:2];
    assign ram_addr_o   = addr_i[RAM_LSB-1:2];
    assign mtime_addr_o = addr_i[MTIME_LSB-1:2];
    assign axi_addr_o   = addr_i[AXI_LSB-1:0];

endmodule

// ==== design/dbus_lanes.sv ====
//////////////////////////////
// Byte lane steering for writes and registered read return
//////////////////////////////
`timescale 1ns/1ps

module dbus_lanes import rv32_pkg::*, dbus_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,

    input  logic      accept_i,
    input  logic      fault_i,
    input  logic      wr_en_i,
    input  region_t   region_i,
    input  word_t     addr_i,
    input  lsu_size_t size_i,
    input  logic      unsigned_i,
    input  word_t     wr_data_i,

    input  word_t     rom_rd_data_i,
    input  word_t     ram_rd_data_i,
    input  word_t     mtime_rd_data_i,
    input  word_t     axi_rd_data_i,
    input  logic      axi_access_fault_i,

    output word_t     wr_data_o,
    output strobe_t   wr_strobe_o,
    output word_t     rd_data_o,
    output logic      err_o
);

    byte_off_t off;
    strobe_t   strb_base;       // Strobe at offset zero

    // Response cycle state
    logic      valid_q;
    logic      fault_q;
    logic      load_q;
    region_t   region_q;
    byte_off_t off_q;
    lsu_size_t size_q;
    logic      unsigned_q;

    word_t     rd_sel;
    word_t     rd_shift;
    word_t     rd_ext;
    logic      sign_b;
    logic      sign_h;

    //////////////////////////////
    // Write path
    //////////////////////////////
    assign off = addr_i[1:0];

    always_comb begin
        case (size_i)
            SIZE_BYTE: strb_base = 4'b0001;
            SIZE_HALF: strb_base = 4'b0011;
            default:   strb_base = 4'b1111;
        endcase
    end

    assign wr_data_o   = wr_data_i << {off, 3'b000};                    // Move to byte lane
    assign wr_strobe_o = wr_en_i ? strobe_t'(strb_base << off) : '0;

    //////////////////////////////
    // Capture on accept
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q  <= 1'b0;
            fault_q  <= 1'b0;
            load_q   <= 1'b0;
            region_q <= REGION_NONE;
        end else begin
            valid_q <= accept_i;
            if (accept_i) begin
                fault_q  <= fault_i;
                load_q   <= ~wr_en_i;
                region_q <= region_i;
            end
        end
    end

    // Access shape, no reset needed
    always_ff @(posedge clk) begin
        if (accept_i) begin
            off_q      <= addr_i[1:0];
            size_q     <= size_i;
            unsigned_q <= unsigned_i;
        end
    end

    //////////////////////////////
    // Read path
    //////////////////////////////
    always_comb begin
        case (region_q)
            REGION_ROM:   rd_sel = rom_rd_data_i;
            REGION_RAM:   rd_sel = ram_rd_data_i;
            REGION_MTIME: rd_sel = mtime_rd_data_i;
            REGION_AXI:   rd_sel = axi_rd_data_i;
            default:      rd_sel = '0;
        endcase
    end

    assign rd_shift = rd_sel >> {off_q, 3'b000};       // Lane down to bit 0
    assign sign_b   = ~unsigned_q & rd_shift[7];
    assign sign_h   = ~unsigned_q & rd_shift[15];

    always_comb begin
        case (size_q)
            SIZE_BYTE: rd_ext = {{(XLEN-8){sign_b}}, rd_shift[7:0]};
            SIZE_HALF: rd_ext = {{(XLEN-16){sign_h}}, rd_shift[15:0]};
            default:   rd_ext = rd_shift;
        endcase
    end

    // Stores and faults return zero
    assign rd_data_o = (load_q & ~fault_q) ? rd_ext : '0;

    // Own fault or external access fault, one cycle after accept
    assign err_o = valid_q & (fault_q | ((region_q == REGION_AXI) & axi_access_fault_i));

endmodule

// ==== design/dbus_params.svh ====
//////////////////////////////
// Data bus memory map and timer divider
// Include wherever bus widths or bases are needed
//////////////////////////////
`ifndef DBUS_PARAMS_SVH
`define DBUS_PARAMS_SVH

//////////////////////////////
// Region bases and widths
//////////////////////////////

// ROM is word addressed
`define DBUS_ROM_BASE   32'h0000_0000
`define DBUS_ROM_AW     10

// RAM is word addressed
`define DBUS_RAM_BASE   32'h1000_0000
`define DBUS_RAM_AW     10

`define DBUS_MTIME_BASE 32'h2000_0000
`define DBUS_MTIME_AW   2               // Four timer words

// External window is byte addressed
`define DBUS_AXI_BASE   32'h8000_0000
`define DBUS_AXI_AW     16

//////////////////////////////
// Machine timer
//////////////////////////////
`define MTIME_TICK_DIV  4               // Clocks per mtime increment

`endif

// ==== design/dbus_pkg.sv ====
//////////////////////////////
// Data bus side types for region decode and access size
//////////////////////////////
package dbus_pkg;

    //////////////////////////////
    // Target region
    //////////////////////////////
    typedef enum logic [2:0] {
        REGION_ROM   = 3'd0,    // Read only program memory
        REGION_RAM   = 3'd1,    // Local data memory
        REGION_MTIME = 3'd2,    // Machine timer registers
        REGION_AXI   = 3'd3,    // External window
        REGION_NONE  = 3'd4     // Unmapped
    } region_t;

    //////////////////////////////
    // Access size
    //////////////////////////////
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,       // Needs even address
        SIZE_WORD = 2'd2        // Needs word aligned address
    } lsu_size_t;

endpackage

// ==== design/dbus_top.sv ====
//////////////////////////////
// Data bus top joining decode, lanes and machine timer
//////////////////////////////
`timescale 1ns/1ps

`include "dbus_params.svh"

module dbus_top import rv32_pkg::*, dbus_pkg::*; (
    input  logic                   clk,
    input  logic                   arst_n_i,

    // Request side
    input  logic                   rd_en_i,
    input  logic                   wr_en_i,
    input  word_t                  addr_i,
    input  lsu_size_t              size_i,
    input  logic                   unsigned_i,
    input  word_t                  wr_data_i,

    // ROM port
    output logic                   rom_rd_en_o,
    output logic [`DBUS_ROM_AW-1:0] rom_addr_o,
    input  word_t                  rom_rd_data_i,

    // RAM port
    output logic                   ram_rd_en_o,
    output logic                   ram_wr_en_o,
    output logic [`DBUS_RAM_AW-1:0] ram_addr_o,
    input  word_t                  ram_rd_data_i,

    // External AXI window
    output logic                   axi_rd_en_o,
    output logic                   axi_wr_en_o,
    output logic [`DBUS_AXI_AW-1:0] axi_addr_o,
    input  word_t                  axi_rd_data_i,
    input  logic                   axi_access_fault_i,
    input  logic                   axi_busy_i,

    // Shared write lanes
    output word_t                  wr_data_o,
    output strobe_t                wr_strobe_o,

    // Response
    output word_t                  rd_data_o,
    output logic                   err_o,
    output logic                   wait_o,

    output logic                   mtime_int_o
);

    //////////////////////////////
    // Internal wires
    //////////////////////////////
    region_t                     region;
    logic                        fault;
    logic                        accept;
    logic                        mtime_rd_en;
    logic                        mtime_wr_en;
    logic [`DBUS_MTIME_AW-1:0]   mtime_addr;
    word_t                       mtime_rd_data;

    dbus_decode decode0 (
        .rd_en_i       (rd_en_i),
        .wr_en_i       (wr_en_i),
        .addr_i        (addr_i),
        .size_i        (size_i),
        .axi_busy_i    (axi_busy_i),
        .region_o      (region),
        .fault_o       (fault),
        .accept_o      (accept),
        .wait_o        (wait_o),
        .rom_rd_en_o   (rom_rd_en_o),
        .ram_rd_en_o   (ram_rd_en_o),
        .ram_wr_en_o   (ram_wr_en_o),
        .mtime_rd_en_o (mtime_rd_en),
        .mtime_wr_en_o (mtime_wr_en),
        .axi_rd_en_o   (axi_rd_en_o),
        .axi_wr_en_o   (axi_wr_en_o),
        .rom_addr_o    (rom_addr_o),
        .ram_addr_o    (ram_addr_o),
        .mtime_addr_o  (mtime_addr),
        .axi_addr_o    (axi_addr_o)
    );

    dbus_lanes lanes0 (
        .clk                (clk),
        .arst_n_i           (arst_n_i),
        .accept_i           (accept),
        .fault_i            (fault),
        .wr_en_i            (wr_en_i),
        .region_i           (region),
        .addr_i             (addr_i),
        .size_i             (size_i),
        .unsigned_i         (unsigned_i),
        .wr_data_i          (wr_data_i),
        .rom_rd_data_i      (rom_rd_data_i),
        .ram_rd_data_i      (ram_rd_data_i),
        .mtime_rd_data_i    (mtime_rd_data),
        .axi_rd_data_i      (axi_rd_data_i),
        .axi_access_fault_i (axi_access_fault_i),
        .wr_data_o          (wr_data_o),
        .wr_strobe_o        (wr_strobe_o),
        .rd_data_o          (rd_data_o),
        .err_o              (err_o)
    );

    // Timer sees the steered lanes like any other target
    mtime mtime0 (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .rd_en_i     (mtime_rd_en),
        .wr_en_i     (mtime_wr_en),
        .addr_i      (mtime_addr),
        .wr_data_i   (wr_data_o),
        .wr_strobe_i (wr_strobe_o),
        .rd_data_o   (mtime_rd_data),
        .mtime_int_o (mtime_int_o)
    );

endmodule

// ==== design/mtime.sv ====
//////////////////////////////
// Machine timer with compare, mapped as four bus words
//////////////////////////////
`timescale 1ns/1ps

`include "dbus_params.svh"

module mtime import rv32_pkg::*; #(
    parameter int TICK_DIV = `MTIME_TICK_DIV    // Clocks per count, 1 or more
) (
    input  logic       clk,
    input  logic       arst_n_i,

    input  logic       rd_en_i,
    input  logic       wr_en_i,
    input  logic [1:0] addr_i,         // 0 mtime lo, 1 mtime hi, 2 cmp lo, 3 cmp hi
    input  word_t      wr_data_i,
    input  strobe_t    wr_strobe_i,

    output word_t      rd_data_o,
    output logic       mtime_int_o
);

    localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PW-1:0] presc_q;
    logic          tick;

    logic [63:0]   mtime_q;
    logic [63:0]   mtimecmp_q;
    logic [63:0]   mtime_nxt;
    logic [63:0]   cmp_nxt;

    //////////////////////////////
    // Prescaler
    //////////////////////////////
    assign tick = (presc_q == PW'(TICK_DIV - 1));

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            presc_q <= '0;
        end else if (tick) begin
            presc_q <= '0;
        end else begin
            presc_q <= presc_q + 1'b1;
        end
    end

    //////////////////////////////
    // Next register values
    //////////////////////////////
    always_comb begin
        mtime_nxt = tick ? mtime_q + 64'd1 : mtime_q;
        cmp_nxt   = mtimecmp_q;
        // Bus bytes override the tick
        if (wr_en_i) begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (wr_strobe_i[b]) begin
                    case (addr_i)
                        2'd0:    mtime_nxt[8*b +: 8]      = wr_data_i[8*b +: 8];
                        2'd1:    mtime_nxt[XLEN+8*b +: 8] = wr_data_i[8*b +: 8];
                        2'd2:    cmp_nxt[8*b +: 8]        = wr_data_i[8*b +: 8];
                        default: cmp_nxt[XLEN+8*b +: 8]   = wr_data_i[8*b +: 8];
                    endcase
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;       // No interrupt out of reset
        end else begin
            mtime_q    <= mtime_nxt;
            mtimecmp_q <= cmp_nxt;
        end
    end

    //////////////////////////////
    // Read port, one cycle
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            case (addr_i)
                2'd0:    rd_data_o <= mtime_q[XLEN-1:0];
                2'd1:    rd_data_o <= mtime_q[63:XLEN];
                2'd2:    rd_data_o <= mtimecmp_q[XLEN-1:0];
                default: rd_data_o <= mtimecmp_q[63:XLEN];
            endcase
        end
    end

    // Level interrupt
    assign mtime_int_o = (mtime_q >= mtimecmp_q);

endmodule

// ==== design/rv32_pkg.sv ====
//////////////////////////////
// Architectural word types shared by the bus blocks
//////////////////////////////
package rv32_pkg;

    // Data path width
    localparam int XLEN = 32;

    // Data or address word
    typedef logic [XLEN-1:0] word_t;

    // One write enable per byte lane
    typedef logic [XLEN/8-1:0] strobe_t;

    // Byte position inside a word
    typedef logic [1:0] byte_off_t;

endpackage

// ==== files.f ====
+incdir+design
design/rv32_pkg.sv
design/dbus_pkg.sv
design/dbus_decode.sv
design/dbus_lanes.sv
design/mtime.sv
design/dbus_top.sv
tb/dbus_assert.sv
tb/dbus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run, status follows the testbench verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module dbus_tb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep "SIMULATION PASSED" > /dev/null \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }

// ==== tb/dbus_assert.sv ====
//////////////////////////////
// Bus protocol assertions bound into the data bus top
//////////////////////////////
`timescale 1ns/1ps

`include "dbus_params.svh"

module dbus_assert import rv32_pkg::*; (
    input logic       clk,
    input logic       arst_n_i,
    input logic       rd_en_i,
    input logic       wr_en_i,
    input word_t      addr_i,
    input logic       axi_busy_i,
    input logic       wait_o,
    input logic       err_o,
    input logic [6:0] en_i      // All target enables
);

    logic req;      // Request present on the bus
    logic in_axi;   // Address inside the external window

    assign req    = rd_en_i | wr_en_i;
    assign in_axi = ((addr_i >> `DBUS_AXI_AW) == (`DBUS_AXI_BASE >> `DBUS_AXI_AW));

    // One target at a time
    enables_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0(en_i))
        else $error("more than one target enable high");

    // Wait only holds AXI requests while the window is busy
    wait_axi_only: assert property (@(posedge clk) disable iff (!arst_n_i)
        wait_o |-> (req && in_axi && axi_busy_i))
        else $error("wait_o high without a busy AXI request");

    // Errors follow a request taken without wait
    err_after_accept: assert property (@(posedge clk) disable iff (!arst_n_i)
        err_o |-> $past(req && !wait_o))
        else $error("err_o without accept in previous cycle");

endmodule

bind dbus_top dbus_assert asrt0 (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .rd_en_i    (rd_en_i),
    .wr_en_i    (wr_en_i),
    .addr_i     (addr_i),
    .axi_busy_i (axi_busy_i),
    .wait_o     (wait_o),
    .err_o      (err_o),
    .en_i       ({rom_rd_en_o, ram_rd_en_o, ram_wr_en_o, mtime_rd_en, mtime_wr_en,
                  axi_rd_en_o, axi_wr_en_o})
);

// ==== tb/dbus_tb.sv ====
//////////////////////////////
// Data bus testbench with memory models and reference checker
//////////////////////////////
`timescale 1ns/1ps

`include "dbus_params.svh"

module dbus_tb import rv32_pkg::*, dbus_pkg::*;;

    localparam int    CLK_PERIOD = 4;
    // Requests issued by the sequence with timer polling at its cap
    localparam int    N_TRANS    = 2*2*60 + 22 + 4*10 + 2*2*80 + 8 + 300;
    localparam word_t K_CMP      = 32'd40;  // Timer compare value

    typedef struct packed {
        word_t data;
        logic  err;
        logic  flt;     // Request faults in decode
        logic  chk;     // Data is predictable
        logic  wok;     // Write reaches a target
        logic  tmr;     // Timer read with interrupt check
        logic  irq;
    } exp_t;

    logic clk, arst_n_i, rd_en_i, wr_en_i, unsigned_i, axi_busy_i;
    word_t addr_i, wr_data_i, wr_data_o, rd_data_o;
    lsu_size_t size_i;
    strobe_t wr_strobe_o;
    logic rom_rd_en_o, ram_rd_en_o, ram_wr_en_o, axi_rd_en_o, axi_wr_en_o;
    logic err_o, wait_o, mtime_int_o;
    logic [`DBUS_ROM_AW-1:0] rom_addr_o;
    logic [`DBUS_RAM_AW-1:0] ram_addr_o;
    logic [`DBUS_AXI_AW-1:0] axi_addr_o;
    word_t rom_rd_data_i = '0;
    word_t ram_rd_data_i = '0;
    word_t axi_rd_data_i = '0;
    logic  axi_access_fault_i = 1'b0;

    word_t ram_mem[1024], ram_shadow[1024];
    word_t axi_mem[16384], axi_shadow[16384];
    word_t cmp_shadow[2];
    exp_t  exp_q[$];
    logic [31:0] lcg_state = 32'h9c31d16a;
    int    err_cnt = 0;
    logic  tmr_phase = 1'b0;
    logic  seen_ge_k = 1'b0;

    dbus_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    //////////////////////////////
    // Helpers and reference
    //////////////////////////////
    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state ^ (lcg_state >> 15);    // Mix weak low bits
    endfunction

    function automatic word_t rom_word(logic [9:0] wa);
        return {6'h2b, wa, 6'h15, ~wa};
    endfunction

    function automatic region_t region_of(word_t a);
        if ((a >> 12) == (`DBUS_ROM_BASE >> 12))   return REGION_ROM;
        if ((a >> 12) == (`DBUS_RAM_BASE >> 12))   return REGION_RAM;
        if ((a >> 4) == (`DBUS_MTIME_BASE >> 4))   return REGION_MTIME;
        if ((a >> 16) == (`DBUS_AXI_BASE >> 16))   return REGION_AXI;
        return REGION_NONE;
    endfunction

    function automatic strobe_t strobe_of(lsu_size_t sz, logic [1:0] off);
        strobe_t s;
        s = (sz == SIZE_BYTE) ? 4'b0001 : (sz == SIZE_HALF) ? 4'b0011 : 4'b1111;
        return s << off;
    endfunction

    function automatic exp_t ref_model(logic wr, word_t a, lsu_size_t sz, logic uns);
        exp_t    e;
        region_t r;
        word_t   w;
        word_t   sh;
        logic    own;
        r   = region_of(a);
        e   = '0;
        own = (sz == SIZE_HALF && a[0]) || (sz == SIZE_WORD && a[1:0] != 2'b00)
            || r == REGION_NONE || (r == REGION_ROM && wr);
        e.flt = own;
        e.err = own || (r == REGION_AXI && a[15]);
        e.wok = wr && !own;
        case (r)
            REGION_ROM:   w = rom_word(a[11:2]);
            REGION_RAM:   w = ram_shadow[a[11:2]];
            REGION_AXI:   w = axi_shadow[a[15:2]];
            REGION_MTIME: w = cmp_shadow[a[2]];
            default:      w = '0;
        endcase
        sh = w >> (8 * a[1:0]);
        case (sz)
            SIZE_BYTE: e.data = {{24{sh[7] & ~uns}}, sh[7:0]};
            SIZE_HALF: e.data = {{16{sh[15] & ~uns}}, sh[15:0]};
            default:   e.data = sh;
        endcase
        e.chk = !wr && !e.err && (r != REGION_MTIME || a[3]);     // mtime itself runs
        e.tmr = tmr_phase && !wr && r == REGION_MTIME && !a[3];
        return e;
    endfunction

    task automatic apply_write(word_t a, lsu_size_t sz, word_t wd);
        strobe_t s;
        word_t   d;
        s = strobe_of(sz, a[1:0]);
        d = wd << (8 * a[1:0]);
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                case (region_of(a))
                    REGION_RAM: ram_shadow[a[11:2]][8*b +: 8] = d[8*b +: 8];
                    REGION_AXI: axi_shadow[a[15:2]][8*b +: 8] = d[8*b +: 8];
                    REGION_MTIME: if (a[3]) cmp_shadow[a[2]][8*b +: 8] = d[8*b +: 8];
                    default: ;
                endcase
            end
        end
    endtask

    //////////////////////////////
    // Memory models
    //////////////////////////////
    always @(posedge clk) begin
        if (rom_rd_en_o) rom_rd_data_i <= rom_word(rom_addr_o);
        if (ram_rd_en_o) ram_rd_data_i <= ram_mem[ram_addr_o];
        if (axi_rd_en_o) axi_rd_data_i <= axi_mem[axi_addr_o[15:2]];
        for (int b = 0; b < 4; b++) begin
            if (ram_wr_en_o && wr_strobe_o[b])
                ram_mem[ram_addr_o][8*b +: 8] <= wr_data_o[8*b +: 8];
            if (axi_wr_en_o && wr_strobe_o[b])
                axi_mem[axi_addr_o[15:2]][8*b +: 8] <= wr_data_o[8*b +: 8];
        end
        axi_access_fault_i <= (axi_rd_en_o | axi_wr_en_o) & axi_addr_o[15];   // Upper half faults
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic issue(logic wr, word_t a, lsu_size_t sz, logic uns, word_t wd, logic busy);
        exp_t  e;
        logic  acc;
        logic  irq;
        logic  wait_exp;
        word_t r;
        e   = ref_model(wr, a, sz, uns);
        acc = 1'b0;
        irq = 1'b0;
        while (!acc) begin
            @(negedge clk);
            r          = lcg_next();
            rd_en_i    = ~wr;
            wr_en_i    = wr;
            addr_i     = a;
            size_i     = sz;
            unsigned_i = uns;
            wr_data_i  = wd;
            axi_busy_i = busy & r[9];
            irq        = mtime_int_o;       // mtime seen by this read
            wait_exp   = axi_busy_i && !e.flt && region_of(a) == REGION_AXI;
            @(posedge clk);
            assert (wait_o === wait_exp) else begin
                $display("[FAIL] wait_o exp %h got %h", wait_exp, wait_o);
                err_cnt++;
            end
            // External window stays idle while busy
            assert (!(axi_busy_i && (axi_rd_en_o || axi_wr_en_o))) else begin
                $display("AXI enable was high while axi_busy_i was set");
                err_cnt++;
            end
            acc = ~wait_o;
        end
        if (e.wok) begin
            assert (wr_strobe_o == strobe_of(sz, a[1:0])) else begin
                $display("[FAIL] wr_strobe_o exp %h got %h", strobe_of(sz, a[1:0]), wr_strobe_o);
                err_cnt++;
            end
            assert (wr_data_o == (wd << (8 * a[1:0]))) else begin
                $display("[FAIL] wr_data_o exp %h got %h", wd << (8 * a[1:0]), wr_data_o);
                err_cnt++;
            end
            apply_write(a, sz, wd);
        end
        if (e.flt) begin
            assert ({rom_rd_en_o, ram_rd_en_o, ram_wr_en_o, axi_rd_en_o, axi_wr_en_o} == 0)
            else begin
                $display("Faulting access at %h drove a target enable", a);
                err_cnt++;
            end
        end
        e.irq = irq;
        exp_q.push_back(e);
    endtask

    task automatic idle();
        @(negedge clk);
        rd_en_i    = 1'b0;
        wr_en_i    = 1'b0;
        axi_busy_i = 1'b0;
    endtask

    function automatic word_t rnd_addr(word_t base, word_t mask, lsu_size_t sz);
        word_t a;
        a = base | (lcg_next() & mask);
        if (sz == SIZE_HALF) a[0] = 1'b0;
        if (sz == SIZE_WORD) a[1:0] = 2'b00;
        return a;
    endfunction

    // Write then read back in RAM or AXI
    task automatic write_read(word_t base, word_t mask, logic busy);
        word_t     a;
        lsu_size_t sz;
        sz = lsu_size_t'(lcg_next() % 3);
        a  = rnd_addr(base, mask, sz);
        issue(1'b1, a, sz, 1'b0, lcg_next(), busy);
        sz = lsu_size_t'(lcg_next() % 3);
        if (sz == SIZE_HALF) a[0] = 1'b0;
        if (sz == SIZE_WORD) a[1:0] = 2'b00;
        issue(1'b0, a, sz, lcg_next() & 1, 32'h0, busy);
    endtask

    //////////////////////////////
    // Compare process
    //////////////////////////////
    always @(negedge clk) begin : compare_blk
        exp_t e;
        if (exp_q.size() > 0) begin
            e = exp_q.pop_front();
            assert (err_o === e.err) else begin
                $display("[FAIL] err_o exp %h got %h", e.err, err_o);
                err_cnt++;
            end
            if (e.chk) begin
                assert (rd_data_o === e.data) else begin
                    $display("[FAIL] rd_data_o exp %h got %h", e.data, rd_data_o);
                    err_cnt++;
                end
            end
            if (e.tmr) begin
                if (rd_data_o >= K_CMP) seen_ge_k = 1'b1;
                assert (e.irq == (rd_data_o >= K_CMP)) else begin
                    $display("[FAIL] mtime_int_o exp %h got %h", rd_data_o >= K_CMP, e.irq);
                    err_cnt++;
                end
            end
        end else begin
            assert (err_o === 1'b0) else begin
                $display("err_o raised with no accepted request");
                err_cnt++;
            end
        end
    end

    // Watchdog
    initial begin
        #(N_TRANS * 40 * CLK_PERIOD);
        $display("Timeout, run exceeded its transaction budget");
        $display("SIMULATION FAILED");
        $finish;
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        arst_n_i   = 1'b0;
        rd_en_i    = 1'b0;
        wr_en_i    = 1'b0;
        unsigned_i = 1'b0;
        axi_busy_i = 1'b0;
        addr_i     = '0;
        wr_data_i  = '0;
        size_i     = SIZE_WORD;
        for (int i = 0; i < 1024; i++) begin
            ram_mem[i]    = {i[9:0], 2'b10, ~i[9:0], 10'h1a5};
            ram_shadow[i] = ram_mem[i];
        end
        for (int i = 0; i < 16384; i++) begin
            axi_mem[i]    = {i[13:0], 4'h9, ~i[13:0]};
            axi_shadow[i] = axi_mem[i];
        end
        cmp_shadow[0] = '1;
        cmp_shadow[1] = '1;
        repeat (10) @(posedge clk);
        @(negedge clk) arst_n_i = 1'b1;

        // RAM and AXI lanes
        for (int i = 0; i < 60; i++) write_read(`DBUS_RAM_BASE, 32'h3f, 1'b0);
        for (int i = 0; i < 60; i++) write_read(`DBUS_AXI_BASE, 32'h3f, 1'b0);
        // ROM reads and a ROM write
        for (int i = 0; i < 20; i++) issue(1'b0, rnd_addr(`DBUS_ROM_BASE, 32'hfff, SIZE_WORD),
                                          lsu_size_t'(lcg_next() % 3), 1'b1, 32'h0, 1'b0);
        issue(1'b1, `DBUS_ROM_BASE + 32'h40, SIZE_WORD, 1'b0, 32'hdeadbeef, 1'b0);
        issue(1'b0, `DBUS_ROM_BASE + 32'h40, SIZE_WORD, 1'b0, 32'h0, 1'b0);
        // Misaligned and unmapped
        for (int i = 0; i < 10; i++) begin
            issue(i[0], `DBUS_RAM_BASE + 32'h11, SIZE_HALF, 1'b0, 32'h1234, 1'b0);
            issue(i[0], `DBUS_AXI_BASE + 32'h22, SIZE_WORD, 1'b0, 32'h5678, 1'b0);
            issue(i[0], 32'h4000_0000 | (lcg_next() & 32'hffc), SIZE_WORD, 1'b0, 32'h0, 1'b0);
            issue(i[0], `DBUS_MTIME_BASE + 32'h10, SIZE_WORD, 1'b0, 32'h0, 1'b0);
        end
        // Back-pressure and external faults
        for (int i = 0; i < 80; i++) begin
            write_read(`DBUS_AXI_BASE, 32'h803f, 1'b1);
            write_read(`DBUS_RAM_BASE, 32'h3f, 1'b1);
        end
        // Timer compare readback
        issue(1'b1, `DBUS_MTIME_BASE + 8, SIZE_WORD, 1'b0, lcg_next(), 1'b0);
        issue(1'b1, `DBUS_MTIME_BASE + 12, SIZE_WORD, 1'b0, lcg_next(), 1'b0);
        issue(1'b0, `DBUS_MTIME_BASE + 8, SIZE_WORD, 1'b0, 32'h0, 1'b0);
        issue(1'b0, `DBUS_MTIME_BASE + 12, SIZE_WORD, 1'b0, 32'h0, 1'b0);
        // Timer interrupt
        issue(1'b1, `DBUS_MTIME_BASE + 12, SIZE_WORD, 1'b0, 32'h0, 1'b0);
        issue(1'b1, `DBUS_MTIME_BASE + 8, SIZE_WORD, 1'b0, K_CMP, 1'b0);
        issue(1'b1, `DBUS_MTIME_BASE + 4, SIZE_WORD, 1'b0, 32'h0, 1'b0);
        issue(1'b1, `DBUS_MTIME_BASE, SIZE_WORD, 1'b0, 32'h0, 1'b0);
        tmr_phase = 1'b1;
        for (int i = 0; i < 300 && !seen_ge_k; i++) begin
            issue(1'b0, `DBUS_MTIME_BASE, SIZE_WORD, 1'b0, 32'h0, 1'b0);
            idle();
            #1;
        end
        assert (seen_ge_k) else begin
            $display("mtime never reached the compare value");
            err_cnt++;
        end
        repeat (3) idle();

        $display("Run complete, errors %0d", err_cnt);
        if (err_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
